/* common/nebula_pkg.sv */
//******************************
// Shared bus types and address map
// for the carrier and its targets
//******************************
`default_nettype none

package nebula_pkg;

    // One Wishbone request, manager to target
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // Target answer
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Chip pins and logic analyzer
    localparam int NUM_PINS = 38;
    localparam int LA_WIDTH = 128;
    localparam int LA_WORDS = 4;  // 32-bit words of the LA bus

    // Owner index, 0 is nobody
    localparam int OWNER_W = 4;

    // Target slot in adr[27:24]
    localparam int SLOT_LSB   = 24;
    localparam int SLOT_W     = 4;
    localparam int SLOT_SRAM  = 0;
    localparam int SLOT_GPIO  = 1;
    localparam int SLOT_LA    = 2;
    localparam int SLOT_TEAM0 = 3;  // Team k sits at SLOT_TEAM0 + k - 1

    localparam int SRAM_WORDS = 256;

    // GPIO owner register layout
    localparam int PINS_PER_REG    = 8;
    localparam int GPIO_OWNER_REGS = 5;

endpackage

`default_nettype wire

/* src/wb_decoder.sv */
//******************************
// Address slot decoder, one manager
// to SRAM, controllers and teams
//******************************
`timescale 1ns/1ps
`default_nettype none

module wb_decoder #(
    parameter int NUM_TEAMS = 2
) (
    input  wire                 wb_clk_i,
    input  wire                 rst_n_i,
    input  nebula_pkg::wb_req_t m_req_i,
    output nebula_pkg::wb_rsp_t m_rsp_o,
    output nebula_pkg::wb_req_t t_req_o [nebula_pkg::SLOT_TEAM0 + NUM_TEAMS],
    input  nebula_pkg::wb_rsp_t t_rsp_i [nebula_pkg::SLOT_TEAM0 + NUM_TEAMS]
);

    localparam int NUM_TGT = nebula_pkg::SLOT_TEAM0 + NUM_TEAMS;

    logic [nebula_pkg::SLOT_W-1:0] slot;
    logic                          hit;
    logic                          miss_ack_q;  // Answers unmapped slots

    assign slot = m_req_i.adr[nebula_pkg::SLOT_LSB +: nebula_pkg::SLOT_W];
    assign hit  = int'(slot) < NUM_TGT;

    // Same request everywhere, strobes only to the selected slot
    always_comb begin
        for (int t = 0; t < NUM_TGT; t++) begin
            t_req_o[t]     = m_req_i;
            t_req_o[t].cyc = m_req_i.cyc && (int'(slot) == t);
            t_req_o[t].stb = m_req_i.stb && (int'(slot) == t);
        end
    end

    // Response mux, default is the local miss answer
    always_comb begin
        m_rsp_o.ack = miss_ack_q;
        m_rsp_o.dat = '0;
        for (int t = 0; t < NUM_TGT; t++) begin
            if (int'(slot) == t) begin
                m_rsp_o = t_rsp_i[t];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            miss_ack_q <= 1'b0;
        end else begin
            // One pulse per request, never back to back
            miss_ack_q <= m_req_i.cyc && m_req_i.stb && !hit && !miss_ack_q;
        end
    end

endmodule

`default_nettype wire

/* src/sram_wb.sv */
//******************************
// Word SRAM on Wishbone, byte lanes
//******************************
`timescale 1ns/1ps
`default_nettype none

module sram_wb (
    input  wire                 wb_clk_i,
    input  wire                 rst_n_i,
    input  nebula_pkg::wb_req_t req_i,
    output nebula_pkg::wb_rsp_t rsp_o
);

    localparam int AW = $clog2(nebula_pkg::SRAM_WORDS);

    logic [31:0]   mem [nebula_pkg::SRAM_WORDS];
    logic [AW-1:0] idx;
    logic          access;
    logic          ack_q;
    logic [31:0]   rdat_q;

    assign idx    = req_i.adr[AW+1:2];  // Word address
    assign access = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.sel[b]) mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                end
            end
            rdat_q <= mem[idx];  // Old word on a write, unused then
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdat_q;

endmodule

`default_nettype wire

/* src/team_counter.sv */
//******************************
// Sample team design, a counter
// shown on GPIO and LA outputs
//******************************
`timescale 1ns/1ps
`default_nettype none

module team_counter #(
    parameter int TEAM_ID = 1
) (
    input  wire                                  wb_clk_i,
    input  wire                                  rst_n_i,
    input  nebula_pkg::wb_req_t                  req_i,
    output nebula_pkg::wb_rsp_t                  rsp_o,
    output logic [nebula_pkg::NUM_PINS-1:0]      gpio_out_o,
    output logic [nebula_pkg::NUM_PINS-1:0]      gpio_oeb_o,
    output logic [nebula_pkg::LA_WIDTH-1:0]      la_data_out_o
);

    localparam int HI_PINS = nebula_pkg::NUM_PINS - 32;

    logic [1:0]  offset;
    logic        access;
    logic        ack_q;
    logic [31:0] rdat_q;
    logic        en_q;    // CTRL bit 0
    logic [31:0] count_q;

    assign offset = req_i.adr[3:2];  // 0 CTRL, 1 COUNT
    assign access = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            en_q    <= 1'b0;
            count_q <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we && offset == 2'd0) en_q <= req_i.dat[0];
            if (access && req_i.we && offset == 2'd1) begin
                count_q <= req_i.dat;  // Load wins over counting
            end else if (en_q) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            case (offset)
                2'd0:    rdat_q <= {31'd0, en_q};
                2'd1:    rdat_q <= count_q;
                default: rdat_q <= '0;
            endcase
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdat_q;

    // Low 32 pins driven with the count
    assign gpio_out_o    = {{HI_PINS{1'b0}}, count_q};
    assign gpio_oeb_o    = {{HI_PINS{1'b1}}, 32'd0};
    assign la_data_out_o = {{(nebula_pkg::LA_WIDTH-64){1'b0}}, 32'(TEAM_ID), count_q};

endmodule

`default_nettype wire

/* gpio_control/gpio_control.sv */
//******************************
// Pin ownership, picks which team
// drives each chip GPIO
//******************************
`timescale 1ns/1ps
`default_nettype none

module gpio_control #(
    parameter int NUM_TEAMS = 2
) (
    input  wire                                              wb_clk_i,
    input  wire                                              rst_n_i,
    input  nebula_pkg::wb_req_t                              req_i,
    output nebula_pkg::wb_rsp_t                              rsp_o,
    input  wire [nebula_pkg::NUM_PINS*(NUM_TEAMS+1)-1:0]     designs_gpio_out_flat_i,
    input  wire [nebula_pkg::NUM_PINS*(NUM_TEAMS+1)-1:0]     designs_gpio_oeb_flat_i,
    output logic [nebula_pkg::NUM_PINS-1:0]                  gpio_out_o,
    output logic [nebula_pkg::NUM_PINS-1:0]                  gpio_oeb_o
);

    localparam int RW = $clog2(nebula_pkg::GPIO_OWNER_REGS);
    localparam int OW = nebula_pkg::OWNER_W;

    logic [31:0]   owner_q [nebula_pkg::GPIO_OWNER_REGS];
    logic [RW-1:0] reg_idx;
    logic          reg_ok;
    logic          access;
    logic          ack_q;
    logic [31:0]   rdat_q;

    assign reg_idx = req_i.adr[2 +: RW];
    assign reg_ok  = int'(reg_idx) < nebula_pkg::GPIO_OWNER_REGS;
    assign access  = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            for (int r = 0; r < nebula_pkg::GPIO_OWNER_REGS; r++) owner_q[r] <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we && reg_ok) owner_q[reg_idx] <= req_i.dat;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) rdat_q <= reg_ok ? owner_q[reg_idx] : 32'd0;
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdat_q;

    // Pin p takes field p%8 of register p/8
    always_comb begin : pin_mux
        logic [OW-1:0] own;
        for (int p = 0; p < nebula_pkg::NUM_PINS; p++) begin
            own = owner_q[p / nebula_pkg::PINS_PER_REG][(p % nebula_pkg::PINS_PER_REG)*OW +: OW];
            if (int'(own) > NUM_TEAMS) own = '0;  // Unknown team, nobody drives
            gpio_out_o[p] = designs_gpio_out_flat_i[int'(own)*nebula_pkg::NUM_PINS + p];
            gpio_oeb_o[p] = designs_gpio_oeb_flat_i[int'(own)*nebula_pkg::NUM_PINS + p];
        end
    end

endmodule

`default_nettype wire

/* la_control/la_control.sv */
//******************************
// LA word ownership and output mux
//******************************
`timescale 1ns/1ps
`default_nettype none

module la_control #(
    parameter int NUM_TEAMS = 2
) (
    input  wire                                          wb_clk_i,
    input  wire                                          rst_n_i,
    input  nebula_pkg::wb_req_t                          req_i,
    output nebula_pkg::wb_rsp_t                          rsp_o,
    input  wire [nebula_pkg::LA_WIDTH*(NUM_TEAMS+1)-1:0] designs_la_data_out_flat_i,
    output logic [nebula_pkg::LA_WIDTH-1:0]              la_data_out_o
);

    localparam int OW = nebula_pkg::OWNER_W;
    localparam int FW = nebula_pkg::LA_WORDS * OW;  // Used bits of the owner word

    logic [FW-1:0] owner_q;
    logic          at_owner;
    logic          access;
    logic          ack_q;
    logic [31:0]   rdat_q;

    assign at_owner = req_i.adr[3:2] == 2'd0;
    assign access   = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            owner_q <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we && at_owner) owner_q <= req_i.dat[FW-1:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) rdat_q <= at_owner ? {{(32-FW){1'b0}}, owner_q} : 32'd0;
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdat_q;

    always_comb begin : word_mux
        logic [OW-1:0] own;
        for (int w = 0; w < nebula_pkg::LA_WORDS; w++) begin
            own = owner_q[w*OW +: OW];
            if (int'(own) > NUM_TEAMS) own = '0;
            la_data_out_o[w*32 +: 32] =
                designs_la_data_out_flat_i[int'(own)*nebula_pkg::LA_WIDTH + w*32 +: 32];
        end
    end

endmodule

`default_nettype wire

/* src/nebula_top.sv */
//******************************
// Carrier top, manager port in,
// team outputs muxed to the pins
//******************************
`timescale 1ns/1ps
`default_nettype none

module nebula_top #(
    parameter int NUM_TEAMS = 2
) (
    input  wire                                 wb_clk_i,
    input  wire                                 rst_n_i,
    input  wire                                 wbs_stb_i,
    input  wire                                 wbs_cyc_i,
    input  wire                                 wbs_we_i,
    input  wire  [3:0]                          wbs_sel_i,
    input  wire  [31:0]                         wbs_adr_i,
    input  wire  [31:0]                         wbs_dat_i,
    output logic                                wbs_ack_o,
    output logic [31:0]                         wbs_dat_o,
    output logic [nebula_pkg::NUM_PINS-1:0]     gpio_out_o,
    output logic [nebula_pkg::NUM_PINS-1:0]     gpio_oeb_o,
    output logic [nebula_pkg::LA_WIDTH-1:0]     la_data_out_o
);

    localparam int NUM_TGT = nebula_pkg::SLOT_TEAM0 + NUM_TEAMS;
    localparam int NP      = nebula_pkg::NUM_PINS;
    localparam int LW      = nebula_pkg::LA_WIDTH;

    nebula_pkg::wb_req_t m_req;
    nebula_pkg::wb_rsp_t m_rsp;
    nebula_pkg::wb_req_t t_req [NUM_TGT];
    nebula_pkg::wb_rsp_t t_rsp [NUM_TGT];

    // Team k at slice k, slice 0 is the idle pattern
    logic [NP*(NUM_TEAMS+1)-1:0] designs_gpio_out_flat;
    logic [NP*(NUM_TEAMS+1)-1:0] designs_gpio_oeb_flat;
    logic [LW*(NUM_TEAMS+1)-1:0] designs_la_data_out_flat;

    assign m_req = '{cyc: wbs_cyc_i, stb: wbs_stb_i, we: wbs_we_i,
                     sel: wbs_sel_i, adr: wbs_adr_i, dat: wbs_dat_i};
    assign wbs_ack_o = m_rsp.ack;
    assign wbs_dat_o = m_rsp.dat;

    assign designs_gpio_out_flat[NP-1:0]    = '0;
    assign designs_gpio_oeb_flat[NP-1:0]    = '1;  // Outputs disabled
    assign designs_la_data_out_flat[LW-1:0] = '0;

    wb_decoder #(.NUM_TEAMS(NUM_TEAMS)) wb_decoder_i (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .m_req_i  (m_req),
        .m_rsp_o  (m_rsp),
        .t_req_o  (t_req),
        .t_rsp_i  (t_rsp)
    );

    sram_wb sram_wb_i (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (t_req[nebula_pkg::SLOT_SRAM]),
        .rsp_o    (t_rsp[nebula_pkg::SLOT_SRAM])
    );

    gpio_control #(.NUM_TEAMS(NUM_TEAMS)) gpio_control_i (
        .wb_clk_i                (wb_clk_i),
        .rst_n_i                 (rst_n_i),
        .req_i                   (t_req[nebula_pkg::SLOT_GPIO]),
        .rsp_o                   (t_rsp[nebula_pkg::SLOT_GPIO]),
        .designs_gpio_out_flat_i (designs_gpio_out_flat),
        .designs_gpio_oeb_flat_i (designs_gpio_oeb_flat),
        .gpio_out_o              (gpio_out_o),
        .gpio_oeb_o              (gpio_oeb_o)
    );

    la_control #(.NUM_TEAMS(NUM_TEAMS)) la_control_i (
        .wb_clk_i                   (wb_clk_i),
        .rst_n_i                    (rst_n_i),
        .req_i                      (t_req[nebula_pkg::SLOT_LA]),
        .rsp_o                      (t_rsp[nebula_pkg::SLOT_LA]),
        .designs_la_data_out_flat_i (designs_la_data_out_flat),
        .la_data_out_o              (la_data_out_o)
    );

    for (genvar k = 1; k <= NUM_TEAMS; k++) begin : g_team
        team_counter #(.TEAM_ID(k)) team_counter_i (
            .wb_clk_i      (wb_clk_i),
            .rst_n_i       (rst_n_i),
            .req_i         (t_req[nebula_pkg::SLOT_TEAM0 + k - 1]),
            .rsp_o         (t_rsp[nebula_pkg::SLOT_TEAM0 + k - 1]),
            .gpio_out_o    (designs_gpio_out_flat[k*NP +: NP]),
            .gpio_oeb_o    (designs_gpio_oeb_flat[k*NP +: NP]),
            .la_data_out_o (designs_la_data_out_flat[k*LW +: LW])
        );
    end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
//******************************
// Free-running testbench clock
//******************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* tests/tb_nebula.sv */
//******************************
// Top level testbench with bus tasks
// and self-checks for the carrier
//******************************
`timescale 1ns/1ps
`default_nettype none

module tb_nebula;

    localparam int NUM_TEAMS = 2;
    // About 60 accesses of 2 cycles each plus reset, well below the limit
    localparam int MAX_CYCLES = 2000;
    localparam logic [31:0] GPIO_BASE  = 32'h0100_0000;
    localparam logic [31:0] LA_BASE    = 32'h0200_0000;
    localparam logic [31:0] TEAM1_BASE = 32'h0300_0000;
    localparam logic [31:0] TEAM2_BASE = 32'h0400_0000;
    localparam logic [31:0] MISS_ADR   = 32'h0900_0000;  // Slot 9 has no target

    logic                              clk;
    logic                              rst_n;
    logic                              wbs_stb;
    logic                              wbs_cyc;
    logic                              wbs_we;
    logic [3:0]                        wbs_sel;
    logic [31:0]                       wbs_adr;
    logic [31:0]                       wbs_dat;
    logic                              wbs_ack;
    logic [31:0]                       wbs_rdat;
    logic [nebula_pkg::NUM_PINS-1:0]   gpio_out;
    logic [nebula_pkg::NUM_PINS-1:0]   gpio_oeb;
    logic [nebula_pkg::LA_WIDTH-1:0]   la_out;
    int                                cycle_cnt = 0;

    tb_clock_gen #(.PERIOD_NS(8.0)) tb_clock_gen_i (.clk_o(clk));

    nebula_top #(.NUM_TEAMS(NUM_TEAMS)) nebula_top_i (
        .wb_clk_i      (clk),
        .rst_n_i       (rst_n),
        .wbs_stb_i     (wbs_stb),
        .wbs_cyc_i     (wbs_cyc),
        .wbs_we_i      (wbs_we),
        .wbs_sel_i     (wbs_sel),
        .wbs_adr_i     (wbs_adr),
        .wbs_dat_i     (wbs_dat),
        .wbs_ack_o     (wbs_ack),
        .wbs_dat_o     (wbs_rdat),
        .gpio_out_o    (gpio_out),
        .gpio_oeb_o    (gpio_oeb),
        .la_data_out_o (la_out)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    task automatic stop_on_error(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string what, input logic [127:0] got,
                                input logic [127:0] exp);
        value_match: assert (got === exp)
            else stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    // One Wishbone access held until its ack
    task automatic bus_access(input logic write, input logic [3:0] sel,
                              input logic [31:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int waited;
        @(negedge clk);
        bus_idle: assert (!wbs_ack)
            else stop_on_error($sformatf("ack high before request to %h", adr));
        wbs_cyc = 1'b1;
        wbs_stb = 1'b1;
        wbs_we  = write;
        wbs_sel = sel;
        wbs_adr = adr;
        wbs_dat = wdat;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wbs_ack);
        ack_latency: assert (waited == 1)
            else stop_on_error($sformatf("ack after %0d cycles at %h", waited, adr));
        rdat    = wbs_rdat;  // Valid in the ack cycle
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
        logic [31:0] unused;
        bus_access(1'b1, sel, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
        bus_access(1'b0, 4'hF, adr, 32'd0, dat);
    endtask

    // Test words spread over the SRAM in slot 0
    function automatic logic [31:0] sram_addr(input int i);
        return 32'(i * 20);
    endfunction

    initial begin : stimulus
        int           seed;
        logic [31:0]  sram_model [16];
        logic [3:0]   lane_pat [8];
        logic [31:0]  rd;
        logic [31:0]  wr;
        logic [31:0]  team2_count;
        logic [31:0]  cnt_a;
        logic [31:0]  cnt_b;
        logic [nebula_pkg::NUM_PINS-1:0] exp_out;
        logic [nebula_pkg::NUM_PINS-1:0] exp_oeb;
        seed     = 57;
        lane_pat = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                     4'b0011, 4'b1100, 4'b0101, 4'b1010};
        rst_n    = 1'b0;
        wbs_stb  = 1'b0;
        wbs_cyc  = 1'b0;
        wbs_we   = 1'b0;
        wbs_sel  = 4'h0;
        wbs_adr  = 32'd0;
        wbs_dat  = 32'd0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Nobody owns anything yet
        expect_equal("gpio_oeb_o after reset", gpio_oeb, {nebula_pkg::NUM_PINS{1'b1}});
        expect_equal("gpio_out_o after reset", gpio_out, 128'd0);
        expect_equal("la_data_out_o after reset", la_out, 128'd0);

        for (int i = 0; i < 16; i++) begin
            sram_model[i] = $random(seed);
            wb_write(sram_addr(i), sram_model[i], 4'hF);
        end
        for (int i = 0; i < 8; i++) begin
            wr = $random(seed);
            wb_write(sram_addr(2 * i + 1), wr, lane_pat[i]);
            for (int b = 0; b < 4; b++) begin
                if (lane_pat[i][b]) sram_model[2 * i + 1][8 * b +: 8] = wr[8 * b +: 8];
            end
        end
        for (int i = 0; i < 16; i++) begin
            wb_read(sram_addr(i), rd);
            expect_equal($sformatf("SRAM word %0d", i), rd, sram_model[i]);
        end

        wb_read(MISS_ADR, rd);
        expect_equal("unmapped slot read", rd, 128'd0);

        team2_count = $random(seed);
        wb_write(TEAM2_BASE + 32'd4, team2_count, 4'hF);
        wb_write(GPIO_BASE, 32'h2222_2222, 4'hF);          // Pins 0 to 7
        wb_write(GPIO_BASE + 32'd4, 32'h2222_2222, 4'hF);  // Pins 8 to 15
        for (int r = 0; r < nebula_pkg::GPIO_OWNER_REGS; r++) begin
            wb_read(GPIO_BASE + 32'(4 * r), rd);
            expect_equal($sformatf("GPIO owner reg %0d", r), rd,
                         (r < 2) ? 32'h2222_2222 : 32'd0);
        end
        for (int p = 0; p < nebula_pkg::NUM_PINS; p++) begin
            exp_out[p] = (p < 16) ? team2_count[p] : 1'b0;
            exp_oeb[p] = (p >= 16);
        end
        expect_equal("gpio_out_o routed", gpio_out, exp_out);
        expect_equal("gpio_oeb_o routed", gpio_oeb, exp_oeb);

        // Word 1 to team 1 and word 2 to team 2
        wb_write(LA_BASE, 32'h0000_0210, 4'hF);
        wb_read(LA_BASE, rd);
        expect_equal("LA owner reg", rd, 32'h0000_0210);
        // Team word 1 holds its id and word 2 is always zero
        expect_equal("la_data_out_o routed", la_out, {32'd0, 32'd0, 32'd1, 32'd0});

        wb_write(TEAM1_BASE, 32'd1, 4'hF);
        wb_read(TEAM1_BASE + 32'd4, cnt_a);
        wb_read(TEAM1_BASE + 32'd4, cnt_b);
        count_runs: assert (cnt_b > cnt_a)
            else stop_on_error($sformatf("enabled count %h not above %h", cnt_b, cnt_a));
        wb_write(TEAM1_BASE, 32'd0, 4'hF);
        wb_read(TEAM1_BASE + 32'd4, cnt_a);
        wb_read(TEAM1_BASE + 32'd4, cnt_b);
        expect_equal("disabled count", cnt_b, cnt_a);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
common/nebula_pkg.sv
src/wb_decoder.sv
src/sram_wb.sv
src/team_counter.sv
gpio_control/gpio_control.sv
la_control/la_control.sv
src/nebula_top.sv
tests/tb_clock_gen.sv
tests/tb_nebula.sv

/* Bender.yml */
package:
  name: nebula

sources:
  - common/nebula_pkg.sv
  - src/wb_decoder.sv
  - src/sram_wb.sv
  - src/team_counter.sv
  - gpio_control/gpio_control.sv
  - la_control/la_control.sv
  - src/nebula_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_nebula.sv
